/* logic/readout_pkg.sv */
package readout_pkg;

    // header completion from the event header path
    typedef struct packed {
        logic [3:0]  spare;
        logic [11:0] upper_addr;
        logic [7:0]  err_code;
    } hdr_word_s;

    // front-end completion, only the low word carries status
    typedef struct packed {
        logic [31:0] spare;
        logic [31:0] err_code;
    } cmpl_word_s;

    // nack asking for a single fragment
    typedef struct packed {
        logic        allow;
        logic        full;
        logic [2:0]  spare_hi;
        logic [10:0] qwords;
        logic [11:0] upper_addr;
        logic        spare_lo;
        logic [18:0] offset;
    } nack_frag_s;

    // nack asking for the whole event again
    typedef struct packed {
        logic        allow;
        logic        full;
        logic [13:0] ign_hi;
        logic [11:0] upper_addr;
        logic [19:0] ign_lo;
    } nack_full_s;

    // the full flag tells which view applies
    typedef union packed {
        nack_frag_s frag;
        nack_full_s whole;
    } nack_word_u;

    // addresses and length in qwords
    typedef struct packed {
        logic [11:0] upper_addr;
        logic [18:0] lower_addr;
        logic [12:0] length;
    } read_cmd_s;

    typedef struct packed {
        logic [11:0] upper_addr;
        logic        zero;
        logic [18:0] length;
    } ctrl_word_s;

    typedef struct packed {
        logic        last;
        logic [63:0] data;
    } data_beat_s;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        ISSUE_CMD  = 2'd1,
        ISSUE_CTRL = 2'd2,
        DONE       = 2'd3
    } readout_state_e;

endpackage

/* logic/readout_fsm.sv */
`timescale 1ns/1ps

module readout_fsm (
    input  logic                        aclk,
    input  logic                        memresetn,
    input  logic                        nack_valid_i,
    input  logic                        join_valid_i,
    input  logic                        allowed_i,
    input  logic                        cmd_ready_i,
    input  logic                        ctrl_ready_i,
    input  logic                        mover_done_i,
    output readout_pkg::readout_state_e state_o,
    output logic                        cmd_valid_o,
    output logic                        ctrl_valid_o,
    output logic                        accept_cmpl_o,
    output logic                        accept_nack_o,
    output logic                        is_nack_o
);

    readout_pkg::readout_state_e state;
    logic                        is_nack;
    logic                        done_seen;
    logic                        cmd_xfer;

    assign cmd_xfer     = cmd_valid_o && cmd_ready_i;
    assign state_o      = state;
    assign cmd_valid_o  = (state == readout_pkg::ISSUE_CMD);
    assign ctrl_valid_o = (state == readout_pkg::ISSUE_CTRL);
    assign is_nack_o    = is_nack;

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            state         <= readout_pkg::IDLE;
            is_nack       <= 1'b0;
            done_seen     <= 1'b0;
            accept_cmpl_o <= 1'b0;
            accept_nack_o <= 1'b0;
        end else begin
            // readies go out the cycle after the mover takes the command
            accept_cmpl_o <= cmd_xfer && !is_nack;
            accept_nack_o <= cmd_xfer && is_nack;
            // a short event can finish while the ctrl word is still stalled
            if (cmd_xfer) begin
                done_seen <= 1'b0;
            end else if (mover_done_i) begin
                done_seen <= 1'b1;
            end
            case (state)
                readout_pkg::IDLE: begin
                    // nack wins over completions, and needs no credit
                    is_nack <= nack_valid_i;
                    if (nack_valid_i || (join_valid_i && allowed_i)) begin
                        state <= readout_pkg::ISSUE_CMD;
                    end
                end
                readout_pkg::ISSUE_CMD: begin
                    if (cmd_ready_i) begin
                        state <= readout_pkg::ISSUE_CTRL;
                    end
                end
                readout_pkg::ISSUE_CTRL: begin
                    if (ctrl_ready_i) begin
                        state <= readout_pkg::DONE;
                    end
                end
                default: begin
                    if (done_seen || mover_done_i) begin
                        state <= readout_pkg::IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* logic/allow_counter.sv */
`timescale 1ns/1ps

module allow_counter (
    input  logic aclk,
    input  logic memresetn,
    input  logic allow_i,
    input  logic consume_i,
    output logic allowed_o
);

    // events we may still start
    logic [12:0] credits;

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            credits   <= '0;
            allowed_o <= 1'b0;
        end else begin
            // credit and consume together leave the count alone
            if (allow_i && !consume_i) begin
                credits <= credits + 13'd1;
            end else if (!allow_i && consume_i) begin
                credits <= credits - 13'd1;
            end
            // compare is pipelined; the FSM can't get back to IDLE
            // before this catches up with a consume
            allowed_o <= (credits != 13'd0);
        end
    end

endmodule

/* logic/completion_gate.sv */
`timescale 1ns/1ps

module completion_gate (
    input  logic                          aclk,
    input  logic                          memresetn,
    input  logic [3:0]                    tio_mask_i,
    input  readout_pkg::hdr_word_s        hdr_i,
    input  logic                          hdr_valid_i,
    input  readout_pkg::cmpl_word_s [3:0] cmpl_i,
    input  logic [3:0]                    cmpl_valid_i,
    input  logic                          accept_i,
    output logic                          cmpl_ready_o,
    output logic                          join_valid_o,
    output logic                          any_err_o
);

    logic [4:0] err_hit;
    logic [4:0] err_flags;

    // a masked channel counts as present, so it never holds up the join
    assign join_valid_o = hdr_valid_i && (&(cmpl_valid_i | tio_mask_i));

    // one shared ready for header and all four channels
    assign cmpl_ready_o = accept_i;

    always_comb begin
        // bit 4 is the header, bits 3:0 the front-end channels
        err_hit[4] = hdr_valid_i && accept_i && (|hdr_i.err_code);
        for (int i = 0; i < 4; i++) begin
            err_hit[i] = cmpl_valid_i[i] && accept_i && (|cmpl_i[i].err_code);
        end
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            err_flags <= '0;
            any_err_o <= 1'b0;
        end else begin
            // sticky until reset
            err_flags <= err_flags | err_hit;
            // extra stage keeps the wide OR off the transfer path
            any_err_o <= |err_flags;
        end
    end

endmodule

/* logic/readout_cmd_builder.sv */
`timescale 1ns/1ps

module readout_cmd_builder #(
    parameter logic [18:0] START_OFFSET = 19'h40,
    parameter logic [12:0] FULL_QWORDS  = 13'd16
) (
    input  logic                     aclk,
    input  logic                     capture_i,
    input  readout_pkg::hdr_word_s   hdr_i,
    input  readout_pkg::nack_word_u  nack_i,
    input  logic                     nack_valid_i,
    output readout_pkg::read_cmd_s   cmd_o,
    output readout_pkg::ctrl_word_s  ctrl_o
);

    readout_pkg::read_cmd_s next_cmd;
    logic                   frag_nack;

    // only a valid nack with full clear is a fragment request
    assign frag_nack = nack_valid_i && !nack_i.frag.full;

    always_comb begin
        if (frag_nack) begin
            next_cmd.upper_addr = nack_i.frag.upper_addr;
            next_cmd.lower_addr = nack_i.frag.offset + START_OFFSET;
            next_cmd.length     = {2'b00, nack_i.frag.qwords};
        end else begin
            // whole event, either fresh or asked for again
            if (nack_valid_i) begin
                next_cmd.upper_addr = nack_i.whole.upper_addr;
            end else begin
                next_cmd.upper_addr = hdr_i.upper_addr;
            end
            next_cmd.lower_addr = START_OFFSET;
            next_cmd.length     = FULL_QWORDS;
        end
    end

    // sources are stable in IDLE, so the last capture is the one used
    always_ff @(posedge aclk) begin
        if (capture_i) begin
            cmd_o             <= next_cmd;
            ctrl_o.upper_addr <= next_cmd.upper_addr;
            ctrl_o.zero       <= 1'b0;
            ctrl_o.length     <= {6'd0, next_cmd.length};
        end
    end

endmodule

/* logic/event_mover.sv */
`timescale 1ns/1ps

module event_mover (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  readout_pkg::read_cmd_s  cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    output logic                    mem_req_o,
    output logic [30:0]             mem_addr_o,
    input  logic [63:0]             mem_rdata_i,
    output readout_pkg::data_beat_s beat_o,
    output logic                    beat_valid_o,
    input  logic                    fifo_full_i,
    output logic                    done_o
);

    logic        busy;
    logic [11:0] upper_addr;
    logic [18:0] lower_addr;
    logic [12:0] remaining;
    logic        rd_pending;
    logic        pending_last;
    logic        stall;
    logic        issue;
    logic        cmd_xfer;

    // full comes one entry early, which leaves room for the pending read
    assign stall       = fifo_full_i;
    assign issue       = busy && !stall;
    assign cmd_ready_o = !busy && !rd_pending;
    assign cmd_xfer    = cmd_valid_i && cmd_ready_o;

    assign mem_req_o  = issue;
    assign mem_addr_o = {upper_addr, lower_addr};

    // read data lands one cycle after the request
    assign beat_valid_o = rd_pending;
    assign beat_o.data  = mem_rdata_i;
    assign beat_o.last  = pending_last;

    always_ff @(posedge aclk) begin
        if (cmd_xfer) begin
            upper_addr <= cmd_i.upper_addr;
            lower_addr <= cmd_i.lower_addr;
            remaining  <= cmd_i.length;
        end else if (issue) begin
            lower_addr <= lower_addr + 19'd1;
            remaining  <= remaining - 13'd1;
        end
        if (issue) begin
            pending_last <= (remaining == 13'd1);
        end
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            busy       <= 1'b0;
            rd_pending <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            rd_pending <= issue;
            if (cmd_xfer) begin
                // zero-length request moves nothing
                busy <= (cmd_i.length != 13'd0);
            end else if (issue && remaining == 13'd1) begin
                busy <= 1'b0;
            end
            done_o <= (beat_valid_o && pending_last) ||
                      (cmd_xfer && cmd_i.length == 13'd0);
        end
    end

endmodule

/* logic/event_out_fifo.sv */
`timescale 1ns/1ps

module event_out_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  readout_pkg::data_beat_s wr_i,
    input  logic                    wr_valid_i,
    output logic                    full_o,
    output readout_pkg::data_beat_s rd_o,
    output logic                    rd_valid_o,
    input  logic                    rd_ready_i
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    readout_pkg::data_beat_s mem [FIFO_DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [CW-1:0]           count;
    logic                    rd_xfer;

    assign rd_valid_o = (count != '0);
    assign rd_o       = mem[rd_ptr];
    assign rd_xfer    = rd_valid_o && rd_ready_i;
    // one slot held back for the read the mover already has in flight
    assign full_o     = (count >= CW'(FIFO_DEPTH - 1));

    always_ff @(posedge aclk) begin
        if (wr_valid_i) begin
            mem[wr_ptr] <= wr_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // explicit wrap so depth need not be a power of two
            if (wr_valid_i) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_xfer) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_valid_i && !rd_xfer) begin
                count <= count + 1'b1;
            end else if (!wr_valid_i && rd_xfer) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/readout_top.sv */
`timescale 1ns/1ps

module readout_top #(
    parameter logic [18:0] START_OFFSET = 19'h40,
    parameter logic [12:0] FULL_QWORDS  = 13'd16,
    parameter int          FIFO_DEPTH   = 16
) (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  logic [3:0]              tio_mask_i,
    input  logic                    allow_i,
    // header and front-end completions
    input  readout_pkg::hdr_word_s  s_hdr_data_i,
    input  logic                    s_hdr_valid_i,
    output logic                    s_hdr_ready_o,
    input  readout_pkg::cmpl_word_s s_cmpl0_data_i,
    input  logic                    s_cmpl0_valid_i,
    output logic                    s_cmpl0_ready_o,
    input  readout_pkg::cmpl_word_s s_cmpl1_data_i,
    input  logic                    s_cmpl1_valid_i,
    output logic                    s_cmpl1_ready_o,
    input  readout_pkg::cmpl_word_s s_cmpl2_data_i,
    input  logic                    s_cmpl2_valid_i,
    output logic                    s_cmpl2_ready_o,
    input  readout_pkg::cmpl_word_s s_cmpl3_data_i,
    input  logic                    s_cmpl3_valid_i,
    output logic                    s_cmpl3_ready_o,
    input  readout_pkg::nack_word_u s_nack_data_i,
    input  logic                    s_nack_valid_i,
    output logic                    s_nack_ready_o,
    // output streams
    output readout_pkg::ctrl_word_s m_ctrl_data_o,
    output logic                    m_ctrl_valid_o,
    input  logic                    m_ctrl_ready_i,
    output readout_pkg::data_beat_s m_data_o,
    output logic                    m_data_valid_o,
    input  logic                    m_data_ready_i,
    output logic                    any_err_o,
    // event memory, data returns one cycle after the request
    output logic                    mem_req_o,
    output logic [30:0]             mem_addr_o,
    input  logic [63:0]             mem_rdata_i
);

    readout_pkg::readout_state_e state;
    readout_pkg::read_cmd_s      cmd;
    readout_pkg::data_beat_s     beat;
    logic                        cmd_valid;
    logic                        cmd_ready;
    logic                        accept_cmpl;
    logic                        is_nack;
    logic                        join_valid;
    logic                        allowed;
    logic                        mover_done;
    logic                        beat_valid;
    logic                        fifo_full;
    logic                        cmpl_ready;

    // header and every channel share the one ready
    assign s_hdr_ready_o   = cmpl_ready;
    assign s_cmpl0_ready_o = cmpl_ready;
    assign s_cmpl1_ready_o = cmpl_ready;
    assign s_cmpl2_ready_o = cmpl_ready;
    assign s_cmpl3_ready_o = cmpl_ready;

    readout_fsm u_fsm (
        .aclk(aclk), .memresetn(memresetn),
        .nack_valid_i(s_nack_valid_i), .join_valid_i(join_valid),
        .allowed_i(allowed), .cmd_ready_i(cmd_ready),
        .ctrl_ready_i(m_ctrl_ready_i), .mover_done_i(mover_done),
        .state_o(state), .cmd_valid_o(cmd_valid), .ctrl_valid_o(m_ctrl_valid_o),
        .accept_cmpl_o(accept_cmpl), .accept_nack_o(s_nack_ready_o),
        .is_nack_o(is_nack)
    );

    // a nack readout never spends a credit
    allow_counter u_allow (
        .aclk(aclk), .memresetn(memresetn), .allow_i(allow_i),
        .consume_i(cmd_valid && cmd_ready && !is_nack), .allowed_o(allowed)
    );

    completion_gate u_gate (
        .aclk(aclk), .memresetn(memresetn), .tio_mask_i(tio_mask_i),
        .hdr_i(s_hdr_data_i), .hdr_valid_i(s_hdr_valid_i),
        .cmpl_i({s_cmpl3_data_i, s_cmpl2_data_i, s_cmpl1_data_i, s_cmpl0_data_i}),
        .cmpl_valid_i({s_cmpl3_valid_i, s_cmpl2_valid_i, s_cmpl1_valid_i, s_cmpl0_valid_i}),
        .accept_i(accept_cmpl), .cmpl_ready_o(cmpl_ready),
        .join_valid_o(join_valid), .any_err_o(any_err_o)
    );

    readout_cmd_builder #(.START_OFFSET(START_OFFSET), .FULL_QWORDS(FULL_QWORDS)) u_builder (
        .aclk(aclk), .capture_i(state == readout_pkg::IDLE),
        .hdr_i(s_hdr_data_i), .nack_i(s_nack_data_i), .nack_valid_i(s_nack_valid_i),
        .cmd_o(cmd), .ctrl_o(m_ctrl_data_o)
    );

    event_mover u_mover (
        .aclk(aclk), .memresetn(memresetn),
        .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_rdata_i(mem_rdata_i),
        .beat_o(beat), .beat_valid_o(beat_valid), .fifo_full_i(fifo_full),
        .done_o(mover_done)
    );

    event_out_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .aclk(aclk), .memresetn(memresetn),
        .wr_i(beat), .wr_valid_i(beat_valid), .full_o(fifo_full),
        .rd_o(m_data_o), .rd_valid_o(m_data_valid_o), .rd_ready_i(m_data_ready_i)
    );

endmodule

/* tests/readout_properties.sv */
`timescale 1ns/1ps

module readout_props (
    input logic                        aclk,
    input logic                        memresetn,
    input readout_pkg::readout_state_e state_i,
    input logic                        cmd_valid_i,
    input logic                        ctrl_valid_i,
    input logic                        ctrl_ready_i,
    input logic                        accept_cmpl_i,
    input logic                        accept_nack_i,
    input logic                        wr_valid_i,
    input logic                        at_capacity_i
);

    // ctrl word stays offered until the sink takes it
    ctrl_hold: assert property (@(posedge aclk) disable iff (!memresetn)
        ctrl_valid_i && !ctrl_ready_i |=> ctrl_valid_i)
        else $error("m_ctrl valid dropped before ready");

    cmd_in_state: assert property (@(posedge aclk) disable iff (!memresetn)
        cmd_valid_i |-> state_i == readout_pkg::ISSUE_CMD)
        else $error("cmd_valid outside ISSUE_CMD");

    // one readout is either a nack or a completion set
    accept_one: assert property (@(posedge aclk) disable iff (!memresetn)
        !(accept_cmpl_i && accept_nack_i))
        else $error("accept_cmpl and accept_nack together");

    no_overflow: assert property (@(posedge aclk) disable iff (!memresetn)
        wr_valid_i |-> !at_capacity_i)
        else $error("write into a full output FIFO");

endmodule

bind readout_fsm readout_props u_fsm_props (
    .aclk(aclk), .memresetn(memresetn), .state_i(state),
    .cmd_valid_i(cmd_valid_o), .ctrl_valid_i(ctrl_valid_o), .ctrl_ready_i(ctrl_ready_i),
    .accept_cmpl_i(accept_cmpl_o), .accept_nack_i(accept_nack_o),
    .wr_valid_i(1'b0), .at_capacity_i(1'b0)
);

bind event_out_fifo readout_props u_fifo_props (
    .aclk(aclk), .memresetn(memresetn), .state_i(readout_pkg::IDLE),
    .cmd_valid_i(1'b0), .ctrl_valid_i(1'b0), .ctrl_ready_i(1'b0),
    .accept_cmpl_i(1'b0), .accept_nack_i(1'b0),
    .wr_valid_i(wr_valid_i), .at_capacity_i(count == CW'(FIFO_DEPTH))
);

/* tests/readout_tb.sv */
`timescale 1ns/1ps

module readout_tb;

    localparam logic [18:0] START_OFFSET = 19'h40;
    localparam logic [12:0] FULL_QWORDS  = 13'd16;
    localparam int          FIFO_DEPTH   = 16;
    localparam int          NUM_STEPS    = 30;
    localparam int          RESET_CYCLES = 16;
    // a step plans at most two readouts
    localparam int          CYCLE_LIMIT  = 200 * 2 * NUM_STEPS + RESET_CYCLES;

    logic                    aclk;
    logic                    memresetn;
    logic [3:0]              tio_mask_i;
    logic                    allow_i;
    readout_pkg::hdr_word_s  s_hdr_data_i;
    logic                    s_hdr_valid_i;
    logic                    s_hdr_ready_o;
    readout_pkg::cmpl_word_s cmpl_data [4];
    logic [3:0]              cmpl_valid;
    logic [3:0]              cmpl_ready;
    readout_pkg::nack_word_u s_nack_data_i;
    logic                    s_nack_valid_i;
    logic                    s_nack_ready_o;
    readout_pkg::ctrl_word_s m_ctrl_data_o;
    logic                    m_ctrl_valid_o;
    logic                    m_ctrl_ready_i;
    readout_pkg::data_beat_s m_data_o;
    logic                    m_data_valid_o;
    logic                    m_data_ready_i;
    logic                    any_err_o;
    logic                    mem_req_o;
    logic [30:0]             mem_addr_o;
    logic [63:0]             mem_rdata_i;

    logic [31:0]             lfsr = 32'hb905_e7e5;
    readout_pkg::ctrl_word_s exp_ctrl [$];
    readout_pkg::data_beat_s exp_beats [$];
    int                      cycles = 0;
    int                      allow_pulses = 0;
    int                      cmpl_readouts = 0;
    // any_err_o lags a bad transfer by two edges
    logic                    err_d1 = 1'b0;
    logic                    err_d2 = 1'b0;

    readout_top #(
        .START_OFFSET(START_OFFSET),
        .FULL_QWORDS(FULL_QWORDS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut_i (
        .aclk(aclk), .memresetn(memresetn), .tio_mask_i(tio_mask_i), .allow_i(allow_i),
        .s_hdr_data_i(s_hdr_data_i), .s_hdr_valid_i(s_hdr_valid_i),
        .s_hdr_ready_o(s_hdr_ready_o),
        .s_cmpl0_data_i(cmpl_data[0]), .s_cmpl0_valid_i(cmpl_valid[0]),
        .s_cmpl0_ready_o(cmpl_ready[0]),
        .s_cmpl1_data_i(cmpl_data[1]), .s_cmpl1_valid_i(cmpl_valid[1]),
        .s_cmpl1_ready_o(cmpl_ready[1]),
        .s_cmpl2_data_i(cmpl_data[2]), .s_cmpl2_valid_i(cmpl_valid[2]),
        .s_cmpl2_ready_o(cmpl_ready[2]),
        .s_cmpl3_data_i(cmpl_data[3]), .s_cmpl3_valid_i(cmpl_valid[3]),
        .s_cmpl3_ready_o(cmpl_ready[3]),
        .s_nack_data_i(s_nack_data_i), .s_nack_valid_i(s_nack_valid_i),
        .s_nack_ready_o(s_nack_ready_o),
        .m_ctrl_data_o(m_ctrl_data_o), .m_ctrl_valid_o(m_ctrl_valid_o),
        .m_ctrl_ready_i(m_ctrl_ready_i),
        .m_data_o(m_data_o), .m_data_valid_o(m_data_valid_o), .m_data_ready_i(m_data_ready_i),
        .any_err_o(any_err_o),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_rdata_i(mem_rdata_i)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // mostly clean status, now and then a nonzero code
    function automatic logic [31:0] random_err();
        if (rand_bits(3) == 32'd0) begin
            return rand_bits(32) | 32'd1;
        end
        return 32'd0;
    endfunction

    // memory content: address in the low word, its inverse above
    function automatic logic [63:0] qword_for(input logic [30:0] addr);
        return {~{1'b0, addr}, {1'b0, addr}};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_ctrl(input readout_pkg::ctrl_word_s got,
                                input readout_pkg::ctrl_word_s exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %0t m_ctrl_data_o got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic compare_beat(input readout_pkg::data_beat_s got,
                                input readout_pkg::data_beat_s exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %0t m_data_o got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic compare_err(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %0t any_err_o got %b expected %b",
                                     $time, got, exp));
        end
    endtask

    // one ctrl word and its beats, in address order
    task automatic push_readout(input logic [11:0] upper, input logic [18:0] lower,
                                input logic [12:0] len);
        readout_pkg::ctrl_word_s c;
        readout_pkg::data_beat_s b;
        logic [30:0]             a;
        c.upper_addr = upper;
        c.zero       = 1'b0;
        c.length     = {6'd0, len};
        exp_ctrl.push_back(c);
        for (int i = 0; i < int'(len); i++) begin
            a      = {upper, lower + 19'(i)};
            b.data = qword_for(a);
            b.last = (i == int'(len) - 1);
            exp_beats.push_back(b);
        end
    endtask

    task automatic pulse_allow();
        allow_i <= 1'b1;
        @(posedge aclk);
        allow_i <= 1'b0;
    endtask

    // header plus unmasked channels, masked ones stay invalid
    task automatic present_cmpl();
        readout_pkg::hdr_word_s hdr;
        logic [31:0]            r;
        logic [31:0]            e;
        logic [3:0]             mask;
        r               = rand_bits(4);
        mask            = r[3:0];
        r               = rand_bits(16);
        e               = random_err();
        hdr.spare       = r[15:12];
        hdr.upper_addr  = r[11:0];
        hdr.err_code    = e[7:0];
        for (int i = 0; i < 4; i++) begin
            cmpl_data[i] <= {rand_bits(32), random_err()};
        end
        tio_mask_i    <= mask;
        cmpl_valid    <= ~mask;
        s_hdr_data_i  <= hdr;
        s_hdr_valid_i <= 1'b1;
        push_readout(hdr.upper_addr, START_OFFSET, FULL_QWORDS);
    endtask

    task automatic present_nack(input logic whole);
        readout_pkg::nack_word_u n;
        logic [31:0]             r;
        logic [31:0]             q;
        r = rand_bits(16);
        n = {r[15:0], rand_bits(32)};
        if (whole) begin
            n.whole.full = 1'b1;
            push_readout(n.whole.upper_addr, START_OFFSET, FULL_QWORDS);
        end else begin
            // short fragments keep the run quick
            q              = rand_bits(5);
            n.frag.full    = 1'b0;
            n.frag.qwords  = {6'd0, q[4:0]};
            push_readout(n.frag.upper_addr, n.frag.offset + START_OFFSET, {8'd0, q[4:0]});
        end
        s_nack_data_i  <= n;
        s_nack_valid_i <= 1'b1;
    endtask

    task automatic wait_cmpl_taken();
        do @(posedge aclk); while (!s_hdr_ready_o);
        s_hdr_valid_i <= 1'b0;
        cmpl_valid    <= 4'd0;
    endtask

    task automatic wait_nack_taken();
        do @(posedge aclk); while (!s_nack_ready_o);
        s_nack_valid_i <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_ctrl.size() != 0 || exp_beats.size() != 0) begin
            @(posedge aclk);
        end
    endtask

    // memory answers one cycle after the request
    always @(posedge aclk) begin
        if (mem_req_o) begin
            mem_rdata_i <= qword_for(mem_addr_o);
        end
    end

    // random back-pressure on both output streams
    always @(posedge aclk) begin
        m_data_ready_i <= rand_bits(1) != 32'd0;
        m_ctrl_ready_i <= rand_bits(2) != 32'd0;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure($sformatf("timeout after %0d cycles, readouts did not finish",
                                     cycles));
        end
    end

    always @(posedge aclk) begin : watch_outputs
        logic err_hit;
        if (memresetn) begin
            if (allow_i) begin
                allow_pulses++;
            end
            if (s_hdr_valid_i && s_hdr_ready_o) begin
                cmpl_readouts++;
                if (cmpl_readouts > allow_pulses) begin
                    report_failure("completion readout started without a credit");
                end
            end
            // presented channels go only together with their header
            for (int i = 0; i < 4; i++) begin
                if (cmpl_valid[i] && (cmpl_ready[i] !== (s_hdr_valid_i && s_hdr_ready_o))) begin
                    report_failure($sformatf("completion channel %0d not taken with its header",
                                             i));
                end
            end
            if (m_ctrl_valid_o && m_ctrl_ready_i) begin
                if (exp_ctrl.size() == 0) begin
                    report_failure("control word appeared when none was expected");
                end
                compare_ctrl(m_ctrl_data_o, exp_ctrl.pop_front());
            end
            if (m_data_valid_o && m_data_ready_i) begin
                if (exp_beats.size() == 0) begin
                    report_failure("data beat appeared when none was expected");
                end
                compare_beat(m_data_o, exp_beats.pop_front());
            end
            // header or any taken channel with a nonzero code
            err_hit = s_hdr_valid_i && s_hdr_ready_o && (s_hdr_data_i.err_code != 8'd0);
            for (int i = 0; i < 4; i++) begin
                if (cmpl_valid[i] && cmpl_ready[i] && cmpl_data[i].err_code != 32'd0) begin
                    err_hit = 1'b1;
                end
            end
            compare_err(any_err_o, err_d2);
            err_d2 = err_d1;
            err_d1 = err_d1 | err_hit;
        end
    end

    initial begin
        logic [31:0] kind;
        logic [31:0] r;
        memresetn      = 1'b0;
        tio_mask_i     = 4'd0;
        allow_i        = 1'b0;
        s_hdr_data_i   = '0;
        s_hdr_valid_i  = 1'b0;
        cmpl_valid     = 4'd0;
        s_nack_data_i  = '0;
        s_nack_valid_i = 1'b0;
        m_ctrl_ready_i = 1'b0;
        m_data_ready_i = 1'b0;
        mem_rdata_i    = '0;
        for (int i = 0; i < 4; i++) begin
            cmpl_data[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        // control outputs all quiet while in reset
        if (m_ctrl_valid_o || m_data_valid_o || s_hdr_ready_o || (|cmpl_ready) ||
            s_nack_ready_o || mem_req_o || any_err_o) begin
            report_failure("a control output was high during reset");
        end
        memresetn <= 1'b1;
        repeat (4) @(posedge aclk);
        for (int step = 0; step < NUM_STEPS; step++) begin
            // first eight steps walk every kind once
            kind = (step < 8) ? 32'(step) : rand_bits(3);
            case (kind[2:0])
                3'd0, 3'd1: begin
                    pulse_allow();
                    present_cmpl();
                    wait_cmpl_taken();
                end
                3'd2: begin
                    present_nack(1'b0);
                    wait_nack_taken();
                end
                3'd3: begin
                    present_nack(1'b1);
                    wait_nack_taken();
                end
                3'd4, 3'd5: begin
                    // credit ready too, still the nack goes first
                    pulse_allow();
                    repeat (2) @(posedge aclk);
                    r = rand_bits(1);
                    present_nack(r[0]);
                    present_cmpl();
                    wait_nack_taken();
                    wait_cmpl_taken();
                end
                default: begin
                    // no credit yet, nothing may start
                    present_cmpl();
                    repeat (32) begin
                        @(posedge aclk);
                        if (m_ctrl_valid_o) begin
                            report_failure("control word sent before any credit was given");
                        end
                    end
                    pulse_allow();
                    wait_cmpl_taken();
                end
            endcase
            wait_drained();
        end
        repeat (8) @(posedge aclk);
        // all planned output is out, so nothing more may be offered
        if (!m_ctrl_valid_o && !m_data_valid_o && !mem_req_o) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure("output still active after the last readout finished");
        end
    end

endmodule

/* sim.f */
logic/readout_pkg.sv
logic/readout_fsm.sv
logic/allow_counter.sv
logic/completion_gate.sv
logic/readout_cmd_builder.sv
logic/event_mover.sv
logic/event_out_fifo.sv
logic/readout_top.sv
tests/readout_properties.sv
tests/readout_tb.sv

/* Makefile */
SIM_BIN = obj_dir/readout_tb_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module readout_tb -o readout_tb_sim
	-./$(SIM_BIN) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
